// File: common/cpu_ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

interface cpu_ctrl_if;
    import cpu_pkg::*;

    logic       addr_zp;        // Address from zero-page operand
    logic       pc_inc;         // Step PC
    logic       write_en;       // Cycle writes
    store_src_t store_src;
    alu_op_t    alu_op;
    db_src_t    db_src;
    logic       count_inc;      // Counter adds one
    logic       count_dec;      // Counter subtracts one
    logic       load_a;
    logic       load_x;
    logic       load_y;
    logic       set_nz;         // N and Z from the bus
    logic       set_c_alu;
    logic       set_v_alu;
    // Explicit flag write from CLC, SEC, CLV
    logic       flag_write;
    logic       flag_value;
    logic       flag_sel;       // 0 selects C, 1 selects V

    modport seq (
        output addr_zp, pc_inc, write_en, store_src, alu_op, db_src,
               count_inc, count_dec, load_a, load_x, load_y, set_nz,
               set_c_alu, set_v_alu, flag_write, flag_value, flag_sel
    );

    modport dp (
        input  addr_zp, pc_inc, write_en, store_src, alu_op, db_src,
               count_inc, count_dec, load_a, load_x, load_y, set_nz,
               set_c_alu, set_v_alu, flag_write, flag_value, flag_sel
    );

endinterface : cpu_ctrl_if

`default_nettype wire

// File: common/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    typedef logic [7:0]  data_t;    // Data byte or register value
    typedef logic [15:0] addr_t;    // Bus address or program counter

    // Cycle states of one instruction
    typedef enum logic [1:0] {
        fetch    = 2'd0,            // Opcode read, sync high
        operand  = 2'd1,            // Second byte
        zeropage = 2'd2             // Zero-page read or write
    } cpu_state_t;

    // Supported opcodes, anything else runs as NOP
    typedef enum logic [7:0] {
        op_ora_imm = 8'h09, op_ora_zp = 8'h05,
        op_and_imm = 8'h29, op_and_zp = 8'h25,
        op_eor_imm = 8'h49, op_eor_zp = 8'h45,
        op_adc_imm = 8'h69, op_adc_zp = 8'h65,
        op_cmp_imm = 8'hc9, op_cmp_zp = 8'hc5,
        op_sbc_imm = 8'he9, op_sbc_zp = 8'he5,
        op_lda_imm = 8'ha9, op_lda_zp = 8'ha5,
        op_ldx_imm = 8'ha2, op_ldx_zp = 8'ha6,
        op_ldy_imm = 8'ha0, op_ldy_zp = 8'ha4,
        op_sta_zp  = 8'h85, op_stx_zp = 8'h86, op_sty_zp = 8'h84,
        op_tax     = 8'haa, op_tay    = 8'ha8,
        op_txa     = 8'h8a, op_tya    = 8'h98,
        op_inx     = 8'he8, op_iny    = 8'hc8,
        op_dex     = 8'hca, op_dey    = 8'h88,
        op_clc     = 8'h18, op_sec    = 8'h38, op_clv = 8'hb8,
        op_nop     = 8'hea,
        op_asl_acc = 8'h0a, op_rol_acc = 8'h2a,
        op_lsr_acc = 8'h4a, op_ror_acc = 8'h6a
    } opcode_t;

    typedef enum logic [3:0] {
        alu_or, alu_and, alu_eor, alu_adc,
        alu_pass,                   // Operand straight through, LDA
        alu_cmp, alu_sbc,
        alu_asl, alu_rol, alu_lsr, alu_ror  // Shifts act on A
    } alu_op_t;

    // Internal data bus sources
    typedef enum logic [2:0] {
        db_data, db_alu, db_a, db_x, db_y, db_count
    } db_src_t;

    // Register named by a store, also counter input
    typedef enum logic [1:0] {
        store_a, store_x, store_y
    } store_src_t;

    localparam data_t zero_page_high = 8'h00;  // High address byte in zero-page cycles

endpackage : cpu_pkg

`default_nettype wire

// File: datapath/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire cpu_pkg::data_t  a_in,     // Accumulator
    input  wire cpu_pkg::data_t  b_in,     // Operand byte
    input  wire logic            c_in,
    input  wire cpu_pkg::alu_op_t op,
    output cpu_pkg::data_t       result,
    output logic                 c_out,
    output logic                 v_out
);
    import cpu_pkg::*;

    logic       subtract;
    logic       carry;
    data_t      addend;
    logic [8:0] sum;            // Binary sum with carry out

    assign subtract = (op == alu_sbc) || (op == alu_cmp);
    assign carry    = (op == alu_cmp) ? 1'b1 : c_in;   // Compare ignores C
    assign addend   = subtract ? ~b_in : b_in;
    assign sum      = {1'b0, a_in} + {1'b0, addend} + 9'(carry);

    always_comb
    begin
        c_out = sum[8];
        case (op)
            alu_or:  result = a_in | b_in;
            alu_and: result = a_in & b_in;
            alu_eor: result = a_in ^ b_in;
            alu_asl: {c_out, result} = {a_in, 1'b0};
            alu_rol: {c_out, result} = {a_in, c_in};
            alu_lsr: {result, c_out} = {1'b0, a_in};
            alu_ror: {result, c_out} = {c_in, a_in};
            alu_pass: result = b_in;
            default: result = sum[7:0];                 // ADC, SBC, CMP
        endcase
    end

    // Signed overflow of the adder
    assign v_out = (a_in[7] ^ sum[7]) & (addend[7] ^ sum[7]);

endmodule : alu

`default_nettype wire

// File: datapath/datapath.sv
`timescale 1ns/1ps
`default_nettype none

module datapath #(
    parameter cpu_pkg::addr_t reset_pc = 16'h0200
) (
    input  wire logic           clock,
    input  wire logic           reset,
    input  wire logic           enable,
    input  wire cpu_pkg::data_t data_in,
    cpu_ctrl_if.dp              ctrl,
    output cpu_pkg::addr_t      address,
    output cpu_pkg::data_t      data_out,
    output logic                write_enable,
    output cpu_pkg::addr_t      pc,
    output cpu_pkg::data_t      a,
    output cpu_pkg::data_t      x,
    output cpu_pkg::data_t      y,
    output cpu_pkg::data_t      p
);
    import cpu_pkg::*;

    data_t reg_data;            // Byte read in the previous cycle
    logic  flag_n, flag_v, flag_z, flag_c;
    data_t store_data;
    data_t count_out;
    data_t alu_result;
    logic  alu_c_out, alu_v_out;
    data_t db;                  // Internal data bus

    alu u_alu (
        .a_in   (a),
        .b_in   (reg_data),
        .c_in   (flag_c),
        .op     (ctrl.alu_op),
        .result (alu_result),
        .c_out  (alu_c_out),
        .v_out  (alu_v_out)
    );

    // Register named by store_src, feeds write data and counter
    always_comb
    begin
        case (ctrl.store_src)
            store_x: store_data = x;
            store_y: store_data = y;
            default: store_data = a;
        endcase
    end

    assign count_out = store_data + {8{ctrl.count_dec}} + data_t'(ctrl.count_inc);

    always_comb
    begin
        case (ctrl.db_src)
            db_alu:   db = alu_result;
            db_a:     db = a;
            db_x:     db = x;
            db_y:     db = y;
            db_count: db = count_out;
            default:  db = reg_data;
        endcase
    end

    always_ff @(posedge clock)
    begin
        if (enable)
            reg_data <= data_in;
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            pc     <= reset_pc;
            a      <= '0;
            x      <= '0;
            y      <= '0;
            flag_n <= 1'b0;
            flag_v <= 1'b0;
            flag_z <= 1'b0;
            flag_c <= 1'b0;
        end
        else if (enable)
        begin
            pc <= pc + addr_t'(ctrl.pc_inc);
            if (ctrl.load_a) a <= db;
            if (ctrl.load_x) x <= db;
            if (ctrl.load_y) y <= db;
            if (ctrl.set_nz)
            begin
                flag_n <= db[7];
                flag_z <= (db == 8'h00);
            end
            // Explicit write wins over ALU result
            if (ctrl.flag_write && !ctrl.flag_sel)
                flag_c <= ctrl.flag_value;
            else if (ctrl.set_c_alu)
                flag_c <= alu_c_out;
            if (ctrl.flag_write && ctrl.flag_sel)
                flag_v <= ctrl.flag_value;
            else if (ctrl.set_v_alu)
                flag_v <= alu_v_out;
        end
    end

    assign address      = ctrl.addr_zp ? {zero_page_high, reg_data} : pc;
    assign data_out     = store_data;
    assign write_enable = ctrl.write_en;
    // N V 1 B D I Z C with B set, D and I clear
    assign p = {flag_n, flag_v, 1'b1, 1'b1, 1'b0, 1'b0, flag_z, flag_c};

endmodule : datapath

`default_nettype wire

// File: design/cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core #(
    parameter cpu_pkg::addr_t reset_pc = 16'h0200     // PC after reset
) (
    input  wire logic           clock,
    input  wire logic           reset,
    input  wire logic           enable,         // Freezes the whole core when low
    input  wire cpu_pkg::data_t data_in,        // Asynchronous memory read data

    output cpu_pkg::addr_t      address,
    output cpu_pkg::data_t      data_out,
    output logic                write_enable,
    output logic                sync,           // Opcode fetch cycle

    output cpu_pkg::addr_t      debug_pc,
    output cpu_pkg::data_t      debug_opcode,
    output cpu_pkg::data_t      debug_a,
    output cpu_pkg::data_t      debug_x,
    output cpu_pkg::data_t      debug_y,
    output cpu_pkg::data_t      debug_p
);

    // Decoded control from sequencer to datapath
    cpu_ctrl_if ctrl_bus ();

    sequencer u_sequencer (
        .clock    (clock),
        .reset    (reset),
        .enable   (enable),
        .data_in  (data_in),
        .ctrl     (ctrl_bus),
        .sync     (sync),
        .opcode   (debug_opcode)    // Held opcode seen as a plain byte
    );

    datapath #(
        .reset_pc (reset_pc)
    ) u_datapath (
        .clock        (clock),
        .reset        (reset),
        .enable       (enable),
        .data_in      (data_in),
        .ctrl         (ctrl_bus),
        .address      (address),
        .data_out     (data_out),
        .write_enable (write_enable),
        .pc           (debug_pc),
        .a            (debug_a),
        .x            (debug_x),
        .y            (debug_y),
        .p            (debug_p)
    );

endmodule : cpu_core

`default_nettype wire

// File: dv/cpu_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_asserts (
    input wire logic           clock,
    input wire logic           reset,
    input wire logic           enable,
    input wire logic           sync,
    input wire logic           write_enable,
    input wire cpu_pkg::addr_t address,
    input wire cpu_pkg::addr_t pc,
    input wire cpu_pkg::data_t data_out
);
    import cpu_pkg::*;

    int unsigned fail_count = 0;    // Failed assertions so far

    no_write_in_fetch: assert property (@(posedge clock) disable iff (reset)
        write_enable |-> !sync)
        else begin $error("write_enable high in an opcode fetch"); fail_count++; end

    write_in_zero_page: assert property (@(posedge clock) disable iff (reset)
        write_enable |-> (address[15:8] == zero_page_high))
        else begin $error("Write outside the zero page"); fail_count++; end

    fetch_from_pc: assert property (@(posedge clock) disable iff (reset)
        sync |-> (address == pc))
        else begin $error("Fetch address differs from the program counter"); fail_count++; end

    // A stalled edge changes nothing
    hold_when_stalled: assert property (@(posedge clock) disable iff (reset)
        !enable |=> $stable(address) && $stable(data_out) && $stable(write_enable)
                    && $stable(sync) && $stable(pc))
        else begin $error("Outputs moved while enable was low"); fail_count++; end

endmodule : cpu_asserts

bind cpu_core cpu_asserts u_asserts (
    .clock        (clock),
    .reset        (reset),
    .enable       (enable),
    .sync         (sync),
    .write_enable (write_enable),
    .address      (address),
    .pc           (debug_pc),
    .data_out     (data_out)
);

`default_nettype wire

// File: dv/cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;
    import cpu_pkg::*;

    localparam addr_t       reset_pc     = 16'h0200;
    localparam int          clock_period = 10;
    localparam int          num_instr    = 400;
    localparam logic [15:0] lfsr_seed    = 16'd25095;

    // Every supported opcode for the random program
    localparam opcode_t op_list [37] = '{
        op_ora_imm, op_and_imm, op_eor_imm, op_adc_imm, op_cmp_imm, op_sbc_imm,
        op_lda_imm, op_ldx_imm, op_ldy_imm,
        op_ora_zp, op_and_zp, op_eor_zp, op_adc_zp, op_cmp_zp, op_sbc_zp,
        op_lda_zp, op_ldx_zp, op_ldy_zp, op_sta_zp, op_stx_zp, op_sty_zp,
        op_tax, op_tay, op_txa, op_tya, op_inx, op_iny, op_dex, op_dey,
        op_clc, op_sec, op_clv, op_nop,
        op_asl_acc, op_rol_acc, op_lsr_acc, op_ror_acc
    };

    // Architectural state seen by the model
    typedef struct packed {
        data_t a;
        data_t x;
        data_t y;
        logic  n;
        logic  v;
        logic  z;
        logic  c;
    } model_t;

    logic        clock;
    logic        reset;
    logic        enable;
    data_t       data_in;
    addr_t       address;
    data_t       data_out;
    logic        write_enable;
    logic        sync;
    addr_t       debug_pc;
    data_t       debug_opcode;
    data_t       debug_a;
    data_t       debug_x;
    data_t       debug_y;
    data_t       debug_p;

    data_t       mem [0:65535];         // Asynchronous 64 KB memory
    data_t       zp_model [0:255];      // Zero page as the model sees it
    opcode_t     prog_op [num_instr];
    data_t       prog_arg [num_instr];
    addr_t       prog_pc [num_instr + 1];   // One past the end for the last fetch
    logic [15:0] lfsr_state;

    cpu_core #(
        .reset_pc (reset_pc)
    ) i_dut (
        .clock        (clock),
        .reset        (reset),
        .enable       (enable),
        .data_in      (data_in),
        .address      (address),
        .data_out     (data_out),
        .write_enable (write_enable),
        .sync         (sync),
        .debug_pc     (debug_pc),
        .debug_opcode (debug_opcode),
        .debug_a      (debug_a),
        .debug_x      (debug_x),
        .debug_y      (debug_y),
        .debug_p      (debug_p)
    );

    assign data_in = mem[address];      // Byte shows in the same cycle

    always @(posedge clock)
    begin
        if (write_enable)
            mem[address] <= data_out;
    end

    initial
    begin
        clock = 1'b0;
        forever #(clock_period / 2) clock = ~clock;
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {1'b0, s[15:1]} ^ (s[0] ? 16'hb400 : 16'h0000);  // x^16+x^14+x^13+x^11+1
    endfunction

    // One LFSR step per bit taken
    function automatic data_t take_bits(input int count);
        data_t bits;
        bits = '0;
        for (int i = 0; i < count; i++)
        begin
            bits       = {bits[6:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return bits;
    endfunction

    // 0 implied or accumulator, 1 immediate, 2 zero page
    function automatic logic [1:0] addr_mode(input opcode_t op);
        case (op)
            op_ora_imm, op_and_imm, op_eor_imm, op_adc_imm, op_cmp_imm,
            op_sbc_imm, op_lda_imm, op_ldx_imm, op_ldy_imm:
                return 2'd1;
            op_ora_zp, op_and_zp, op_eor_zp, op_adc_zp, op_cmp_zp, op_sbc_zp,
            op_lda_zp, op_ldx_zp, op_ldy_zp, op_sta_zp, op_stx_zp, op_sty_zp:
                return 2'd2;
            default:
                return 2'd0;
        endcase
    endfunction

    function automatic int instr_cycles(input opcode_t op);
        return (addr_mode(op) == 2'd2) ? 3 : 2;
    endfunction

    function automatic data_t store_value(input model_t s, input opcode_t op);
        case (op)
            op_stx_zp: return s.x;
            op_sty_zp: return s.y;
            default:   return s.a;
        endcase
    endfunction

    // Reference model of one whole instruction
    function automatic model_t apply_instr(input model_t s, input opcode_t op, input data_t arg);
        data_t      m;
        data_t      r;
        logic [8:0] sum;
        logic [2:0] dest;           // 1 A, 2 X, 3 Y, 4 flags only
        m    = (addr_mode(op) == 2'd2) ? zp_model[arg] : arg;
        r    = 8'h00;
        dest = 3'd0;
        case (op)
            op_ora_imm, op_ora_zp: {dest, r} = {3'd1, s.a | m};
            op_and_imm, op_and_zp: {dest, r} = {3'd1, s.a & m};
            op_eor_imm, op_eor_zp: {dest, r} = {3'd1, s.a ^ m};
            op_lda_imm, op_lda_zp: {dest, r} = {3'd1, m};
            op_ldx_imm, op_ldx_zp: {dest, r} = {3'd2, m};
            op_ldy_imm, op_ldy_zp: {dest, r} = {3'd3, m};
            op_adc_imm, op_adc_zp:
            begin
                sum = {1'b0, s.a} + {1'b0, m} + 9'(s.c);
                {dest, r} = {3'd1, sum[7:0]};
                s.v = (s.a[7] == m[7]) && (sum[7] != s.a[7]);   // Same signs in, other sign out
                s.c = sum[8];
            end
            op_sbc_imm, op_sbc_zp:
            begin
                sum = {1'b0, s.a} - {1'b0, m} - 9'(!s.c);     // Borrow is inverted C
                {dest, r} = {3'd1, sum[7:0]};
                s.v = (s.a[7] != m[7]) && (sum[7] != s.a[7]);
                s.c = !sum[8];
            end
            op_cmp_imm, op_cmp_zp:
            begin
                {dest, r} = {3'd4, s.a - m};
                s.c = (s.a >= m);
            end
            op_sta_zp: zp_model[arg] = s.a;
            op_stx_zp: zp_model[arg] = s.x;
            op_sty_zp: zp_model[arg] = s.y;
            op_tax: {dest, r} = {3'd2, s.a};
            op_tay: {dest, r} = {3'd3, s.a};
            op_txa: {dest, r} = {3'd1, s.x};
            op_tya: {dest, r} = {3'd1, s.y};
            op_inx: {dest, r} = {3'd2, s.x + 8'd1};
            op_dex: {dest, r} = {3'd2, s.x - 8'd1};
            op_iny: {dest, r} = {3'd3, s.y + 8'd1};
            op_dey: {dest, r} = {3'd3, s.y - 8'd1};
            op_clc: s.c = 1'b0;
            op_sec: s.c = 1'b1;
            op_clv: s.v = 1'b0;
            op_asl_acc:
            begin
                {dest, r} = {3'd1, s.a[6:0], 1'b0};
                s.c = s.a[7];
            end
            op_rol_acc:
            begin
                {dest, r} = {3'd1, s.a[6:0], s.c};        // Old carry into bit 0
                s.c = s.a[7];
            end
            op_lsr_acc:
            begin
                {dest, r} = {3'd1, 1'b0, s.a[7:1]};
                s.c = s.a[0];
            end
            op_ror_acc:
            begin
                {dest, r} = {3'd1, s.c, s.a[7:1]};
                s.c = s.a[0];
            end
            default: ;              // NOP
        endcase
        case (dest)
            3'd1:    s.a = r;
            3'd2:    s.x = r;
            3'd3:    s.y = r;
            default: ;
        endcase
        if (dest != 3'd0)
        begin
            s.n = r[7];
            s.z = (r == 8'h00);
        end
        return s;
    endfunction

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Verification failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_data(input data_t got, input data_t exp, input string name);
        if (got !== exp)
            stop_with_failure($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic check_addr(input addr_t got, input addr_t exp, input string name);
        if (got !== exp)
            stop_with_failure($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic check_opcode(input opcode_t got, input opcode_t exp, input string name);
        if (got !== exp)
            stop_with_failure($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    initial
    begin : stimulus
        addr_t      pc;
        logic [1:0] mode;
        reset      = 1'b1;
        enable     = 1'b1;
        lfsr_state = lfsr_seed;
        for (int i = 0; i < 65536; i++)
            mem[i] = data_t'(i[15:8] ^ i[7:0]) ^ 8'h3c;   // Background fill
        for (int i = 0; i < 256; i++)
        begin
            mem[i]      = take_bits(8);
            zp_model[i] = mem[i];
        end
        pc = reset_pc;
        for (int i = 0; i < num_instr; i++)
        begin
            prog_op[i] = op_list[take_bits(6) % 37];
            mode       = addr_mode(prog_op[i]);
            // Only 16 zero-page addresses so stores and later loads meet often
            prog_arg[i] = (mode == 2'd2) ? take_bits(4) : take_bits(8);
            prog_pc[i]  = pc;
            mem[pc]     = prog_op[i];
            if (mode != 2'd0)
                mem[pc + 16'd1] = prog_arg[i];
            pc = pc + ((mode == 2'd0) ? 16'd1 : 16'd2);
        end
        prog_pc[num_instr] = pc;
        repeat (3) @(posedge clock);
        reset <= 1'b0;
        forever
        begin
            @(posedge clock);
            enable <= (take_bits(3) != 8'd0);   // Low about one cycle in eight
        end
    end

    // Samples at the falling edge and counts enabled cycles only
    initial
    begin : compare_process
        model_t ms;
        int     fetched;
        int     cycles;
        int     writes;
        int     inst;
        logic   check_due;
        logic   done;
        ms        = '0;
        fetched   = 0;
        cycles    = 0;
        writes    = 0;
        check_due = 1'b0;
        done      = 1'b0;
        while (!done)
        begin
            @(negedge clock);
            if (i_dut.u_asserts.fail_count != 0)
                stop_with_failure("A bound assertion on the core reported an error");
            if (!reset && enable)
            begin
                if (check_due)      // Cycle after a fetch shows the landed results
                begin
                    check_data(debug_a, ms.a, "debug_a");
                    check_data(debug_x, ms.x, "debug_x");
                    check_data(debug_y, ms.y, "debug_y");
                    check_data(debug_p, {ms.n, ms.v, 4'b1100, ms.z, ms.c}, "debug_p");
                    if (fetched <= num_instr)
                        check_opcode(opcode_t'(debug_opcode), prog_op[fetched - 1],
                                     "debug_opcode");
                    check_due = 1'b0;
                    done      = (fetched > num_instr);
                end
                if (sync)
                begin
                    if (fetched > 0)
                    begin
                        if (cycles != instr_cycles(prog_op[fetched - 1]))
                            stop_with_failure($sformatf(
                                "Instruction %0d took %0d enabled cycles instead of %0d",
                                fetched - 1, cycles, instr_cycles(prog_op[fetched - 1])));
                        if ((prog_op[fetched - 1] inside {op_sta_zp, op_stx_zp, op_sty_zp})
                            && (writes != 1))
                            stop_with_failure($sformatf(
                                "Store instruction %0d wrote memory %0d times instead of once",
                                fetched - 1, writes));
                        ms = apply_instr(ms, prog_op[fetched - 1], prog_arg[fetched - 1]);
                    end
                    check_addr(address, prog_pc[fetched], "address");
                    check_addr(debug_pc, prog_pc[fetched], "debug_pc");
                    fetched++;
                    cycles    = 0;
                    writes    = 0;
                    check_due = 1'b1;
                end
                if (write_enable)
                begin
                    inst = fetched - 1;
                    if (!(prog_op[inst] inside {op_sta_zp, op_stx_zp, op_sty_zp}))
                        stop_with_failure($sformatf(
                            "Memory write during instruction %0d, which is no store", inst));
                    check_addr(address, {zero_page_high, prog_arg[inst]}, "address");
                    check_data(data_out, store_value(ms, prog_op[inst]), "data_out");
                    writes++;
                end
                cycles++;
            end
        end
        $display("Verification passed");
        $finish;
    end

    // Worst case of 3 cycles each doubled for stalls and again for margin
    initial
    begin : watchdog
        #(num_instr * 3 * 2 * 2 * clock_period);
        stop_with_failure("The program did not finish before the watchdog expired");
    end

endmodule : cpu_tb

`default_nettype wire

// File: sequencer/sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module sequencer (
    input  wire logic           clock,
    input  wire logic           reset,
    input  wire logic           enable,
    input  wire cpu_pkg::data_t data_in,
    cpu_ctrl_if.seq             ctrl,
    output logic                sync,
    output cpu_pkg::opcode_t    opcode      // Held opcode of current instruction
);
    import cpu_pkg::*;

    cpu_state_t state;
    cpu_state_t next_state;
    logic       is_imm;         // Two-byte immediate
    logic       is_zp;          // Zero page with a third cycle on the bus
    logic       is_store;

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            state  <= fetch;
            opcode <= op_nop;   // No results issued by the first fetch
        end
        else if (enable)
        begin
            state <= next_state;
            if (state == fetch)
                opcode <= opcode_t'(data_in);
        end
    end

    // Addressing mode of the held opcode
    always_comb
    begin
        is_imm   = 1'b0;
        is_zp    = 1'b0;
        is_store = 1'b0;
        case (opcode)
            op_ora_imm, op_and_imm, op_eor_imm, op_adc_imm,
            op_cmp_imm, op_sbc_imm, op_lda_imm, op_ldx_imm, op_ldy_imm:
                is_imm = 1'b1;
            op_ora_zp, op_and_zp, op_eor_zp, op_adc_zp,
            op_cmp_zp, op_sbc_zp, op_lda_zp, op_ldx_zp, op_ldy_zp:
                is_zp = 1'b1;
            op_sta_zp, op_stx_zp, op_sty_zp:
            begin
                is_zp    = 1'b1;
                is_store = 1'b1;
            end
            default: ;          // Implied, accumulator, unknown
        endcase
    end

    always_comb
    begin
        case (state)
            fetch:   next_state = operand;
            operand: next_state = is_zp ? zeropage : fetch;
            default: next_state = fetch;
        endcase
    end

    always_comb
    begin
        ctrl.addr_zp    = 1'b0;
        ctrl.pc_inc     = 1'b0;
        ctrl.write_en   = 1'b0;
        ctrl.alu_op     = alu_pass;
        ctrl.db_src     = db_data;
        ctrl.count_inc  = 1'b0;
        ctrl.count_dec  = 1'b0;
        ctrl.load_a     = 1'b0;
        ctrl.load_x     = 1'b0;
        ctrl.load_y     = 1'b0;
        ctrl.set_nz     = 1'b0;
        ctrl.set_c_alu  = 1'b0;
        ctrl.set_v_alu  = 1'b0;
        ctrl.flag_write = 1'b0;
        ctrl.flag_value = 1'b0;
        ctrl.flag_sel   = 1'b0;

        // Store data and counter input share this select
        case (opcode)
            op_stx_zp, op_inx, op_dex: ctrl.store_src = store_x;
            op_sty_zp, op_iny, op_dey: ctrl.store_src = store_y;
            default:                   ctrl.store_src = store_a;
        endcase

        case (state)
            fetch:
            begin
                ctrl.pc_inc = 1'b1;
                // Results of the previous instruction land at the end of this cycle
                case (opcode)
                    op_ora_imm, op_ora_zp: ctrl.alu_op = alu_or;
                    op_and_imm, op_and_zp: ctrl.alu_op = alu_and;
                    op_eor_imm, op_eor_zp: ctrl.alu_op = alu_eor;
                    op_adc_imm, op_adc_zp: ctrl.alu_op = alu_adc;
                    op_sbc_imm, op_sbc_zp: ctrl.alu_op = alu_sbc;
                    op_cmp_imm, op_cmp_zp: ctrl.alu_op = alu_cmp;
                    op_asl_acc:            ctrl.alu_op = alu_asl;
                    op_rol_acc:            ctrl.alu_op = alu_rol;
                    op_lsr_acc:            ctrl.alu_op = alu_lsr;
                    op_ror_acc:            ctrl.alu_op = alu_ror;
                    default:               ctrl.alu_op = alu_pass;
                endcase
                case (opcode)
                    op_ora_imm, op_ora_zp, op_and_imm, op_and_zp, op_eor_imm, op_eor_zp,
                    op_lda_imm, op_lda_zp:
                    begin
                        ctrl.db_src = db_alu;
                        ctrl.load_a = 1'b1;
                        ctrl.set_nz = 1'b1;
                    end
                    op_adc_imm, op_adc_zp, op_sbc_imm, op_sbc_zp:
                    begin
                        ctrl.db_src    = db_alu;
                        ctrl.load_a    = 1'b1;
                        ctrl.set_nz    = 1'b1;
                        ctrl.set_c_alu = 1'b1;
                        ctrl.set_v_alu = 1'b1;
                    end
                    op_asl_acc, op_rol_acc, op_lsr_acc, op_ror_acc:
                    begin
                        ctrl.db_src    = db_alu;
                        ctrl.load_a    = 1'b1;
                        ctrl.set_nz    = 1'b1;
                        ctrl.set_c_alu = 1'b1;
                    end
                    op_cmp_imm, op_cmp_zp:
                    begin
                        ctrl.db_src    = db_alu;   // Difference only sets flags
                        ctrl.set_nz    = 1'b1;
                        ctrl.set_c_alu = 1'b1;
                    end
                    op_ldx_imm, op_ldx_zp:
                    begin
                        ctrl.load_x = 1'b1;
                        ctrl.set_nz = 1'b1;
                    end
                    op_ldy_imm, op_ldy_zp:
                    begin
                        ctrl.load_y = 1'b1;
                        ctrl.set_nz = 1'b1;
                    end
                    op_tax:
                    begin
                        ctrl.db_src = db_a;
                        ctrl.load_x = 1'b1;
                        ctrl.set_nz = 1'b1;
                    end
                    op_tay:
                    begin
                        ctrl.db_src = db_a;
                        ctrl.load_y = 1'b1;
                        ctrl.set_nz = 1'b1;
                    end
                    op_txa:
                    begin
                        ctrl.db_src = db_x;
                        ctrl.load_a = 1'b1;
                        ctrl.set_nz = 1'b1;
                    end
                    op_tya:
                    begin
                        ctrl.db_src = db_y;
                        ctrl.load_a = 1'b1;
                        ctrl.set_nz = 1'b1;
                    end
                    op_inx, op_iny, op_dex, op_dey:
                    begin
                        ctrl.db_src    = db_count;
                        ctrl.count_inc = (opcode == op_inx) || (opcode == op_iny);
                        ctrl.count_dec = (opcode == op_dex) || (opcode == op_dey);
                        ctrl.load_x    = (opcode == op_inx) || (opcode == op_dex);
                        ctrl.load_y    = (opcode == op_iny) || (opcode == op_dey);
                        ctrl.set_nz    = 1'b1;
                    end
                    op_clc, op_sec, op_clv:
                    begin
                        ctrl.flag_write = 1'b1;
                        ctrl.flag_value = (opcode == op_sec);
                        ctrl.flag_sel   = (opcode == op_clv);
                    end
                    default: ;          // Stores, NOP, unknown
                endcase
            end
            operand:  ctrl.pc_inc = is_imm | is_zp;  // Implied re-reads the next byte
            zeropage:
            begin
                ctrl.addr_zp  = 1'b1;
                ctrl.write_en = is_store;
            end
            default: ;
        endcase
    end

    assign sync = (state == fetch);

endmodule : sequencer

`default_nettype wire

// File: verilog.f
common/cpu_pkg.sv
common/cpu_ctrl_if.sv
datapath/alu.sv
datapath/datapath.sv
sequencer/sequencer.sv
design/cpu_core.sv
dv/cpu_asserts.sv
dv/cpu_tb.sv
